// File: rv_patterns.txt
# P <instruction word hex>          program words, from address 0 upward
# S <address hex> <data hex>        expected stores, in program order
P 10000513  # 00 addi x10, x0, 0x100
P 00500093  # 04 addi x1, x0, 5
P 00708113  # 08 addi x2, x1, 7
P 002081B3  # 0c add  x3, x1, x2
P 40308233  # 10 sub  x4, x1, x3
P 00352023  # 14 sw   x3, 0(x10)
P 00452223  # 18 sw   x4, 4(x10)
P 001222B3  # 1c slt  x5, x4, x1
P 123453B7  # 20 lui  x7, 0x12345
P 6783C413  # 24 xori x8, x7, 0x678
P 005464B3  # 28 or   x9, x8, x5
P 00952423  # 2c sw   x9, 8(x10)
P 06308013  # 30 addi x0, x1, 99
P 00052623  # 34 sw   x0, 12(x10)
P 00452583  # 38 lw   x11, 4(x10)
P 00358633  # 3c add  x12, x11, x3
P 00C52823  # 40 sw   x12, 16(x10)
P 00C08663  # 44 beq  x1, x12, +12 taken
P 00152A23  # 48 sw   x1, 20(x10) skipped
P 00252A23  # 4c sw   x2, 20(x10) skipped
P 00208463  # 50 beq  x1, x2, +8 not taken
P 00C09463  # 54 bne  x1, x12, +8 not taken
P 00209463  # 58 bne  x1, x2, +8 taken
P 00352A23  # 5c sw   x3, 20(x10) skipped
P 008006EF  # 60 jal  x13, +8
P 00152A23  # 64 sw   x1, 20(x10) skipped
P 00D52A23  # 68 sw   x13, 20(x10)
P 0F047713  # 6c andi x14, x8, 0xf0
P 07172793  # 70 slti x15, x14, 0x71
P 00F70833  # 74 add  x16, x14, x15
P 01052C23  # 78 sw   x16, 24(x10)
P 0000006F  # 7c jal  x0, 0
S 00000100 00000011  # x3 = 5 + 12
S 00000104 FFFFFFF4  # x4 = 5 - 17
S 00000108 12345679  # lui, xori, or with slt result
S 0000010C 00000000  # x0 after a write attempt
S 00000110 00000005  # load-use sum
S 00000114 00000064  # jal link
S 00000118 00000071  # andi, slti, add

// File: sources.f
+incdir+.
rv_pkg.sv
rv_decoder.sv
rv_regfile.sv
rv_hazard_unit.sv
rv_execute.sv
rv_core.sv
rv_core_assert.sv
tb_rv_core.sv

// File: Makefile
VERILATOR  = verilator
TOP        = tb_rv_core
FILELIST   = sources.f
COMMON     = --timing --timescale 1ns/1ps
LINT_FLAGS = --lint-only -Wall
SIM_FLAGS  = --binary --assert -j 0
BUILD_DIR  = obj_dir
LOG        = sim.log
FAIL_TEXT  = Finished with errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_TEXT)" >> $(LOG)
	cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_rv_core.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module tb_rv_core;

    localparam int IMEM_WORDS  = 64;
    localparam int DMEM_WORDS  = 256;
    localparam int TAIL_CYCLES = 20;

    logic             clk;
    logic             arst_n;
    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] pc;
    logic             fetch_stall;
    logic [`XLEN-1:0] data_addr;
    logic [`XLEN-1:0] wr_data;
    logic             wr_en;
    logic             rd_en;
    logic [`XLEN-1:0] rd_data;

    logic [`XLEN-1:0] imem [0:IMEM_WORDS-1];
    logic [`XLEN-1:0] dmem [0:DMEM_WORDS-1];
    logic [`XLEN-1:0] exp_addr [$];
    logic [`XLEN-1:0] exp_data [$];

    int     prog_words;
    int     store_count;
    int     error_count;
    int     cycle_count;
    int     timeout_limit;
    int     tail_count;
    logic   done;
    integer seed;

    rv_core uut (
        .clk(clk),
        .arst_n(arst_n),
        .instr(instr),
        .pc(pc),
        .fetch_stall(fetch_stall),
        .data_addr(data_addr),
        .wr_data(wr_data),
        .wr_en(wr_en),
        .rd_en(rd_en),
        .rd_data(rd_data)
    );

    always #5 clk = ~clk;

    // Fetches past the loaded image see NOPs
    assign instr = (pc[`XLEN-1:8] == '0) ? imem[pc[7:2]] : `NOP_INSTR;

    // Read data is only driven while rd_en is high
    assign rd_data = rd_en ? dmem[data_addr[9:2]] : '0;

    always @(posedge clk) begin
        if (!arst_n) begin
            // Fill value differs for every byte address
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= 32'hC0DE_0000 ^ 32'(i * 4);
            end
        end else if (wr_en) begin
            dmem[data_addr[9:2]] <= wr_data;
        end
    end

    task automatic check_value(input string name, input logic [`XLEN-1:0] expected,
                               input logic [`XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic load_patterns();
        int               fd;
        int               n;
        logic [7:0]       tag;
        logic [`XLEN-1:0] first;
        logic [`XLEN-1:0] second;
        string            line;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = `NOP_INSTR;
        end
        fd = $fopen("rv_patterns.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the pattern file rv_patterns.txt");
            error_count++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            tag = 8'h00;
            n = $fgets(line, fd);
            if (n > 0) begin
                n = $sscanf(line, "%c %h %h", tag, first, second);
            end
            if (tag == "P" && n >= 2 && prog_words < IMEM_WORDS) begin
                imem[prog_words] = first;
                prog_words++;
            end else if (tag == "S" && n == 3) begin
                exp_addr.push_back(first);
                exp_data.push_back(second);
            end
        end
        $fclose(fd);
    endtask

    task automatic take_store();
        if (store_count < exp_addr.size()) begin
            check_value($sformatf("store %0d address", store_count),
                        exp_addr[store_count], data_addr);
            check_value($sformatf("store %0d data", store_count),
                        exp_data[store_count], wr_data);
        end else begin
            $display("Unexpected store of %h to address %h after the last expected store",
                     wr_data, data_addr);
            error_count++;
        end
        store_count++;
    endtask

    // Roughly one cycle in four is stalled
    task automatic draw_fetch_stall();
        logic [31:0] r;
        r = $random(seed);
        fetch_stall = (r[1:0] == 2'b00);
    endtask

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        fetch_stall = 1'b0;
        seed = 83563;
        prog_words = 0;
        store_count = 0;
        error_count = 0;
        cycle_count = 0;
        tail_count = 0;
        done = 1'b0;
        load_patterns();
        timeout_limit = 8 * prog_words + 200;

        repeat (4) begin
            @(negedge clk);
            check_value("reset pc", `RESET_PC, pc);
            check_value("reset wr_en", '0, 32'(wr_en));
            check_value("reset rd_en", '0, 32'(rd_en));
        end
        arst_n = 1'b1;

        while (!done) begin
            @(negedge clk);
            cycle_count++;
            if (wr_en) begin
                take_store();
            end
            draw_fetch_stall();
            if (store_count >= exp_addr.size()) begin
                // Keep watching so a late stray store is still caught
                tail_count++;
                if (tail_count >= TAIL_CYCLES) begin
                    done = 1'b1;
                end
            end else if (cycle_count >= timeout_limit) begin
                $display("Timeout reached after %0d cycles with %0d of %0d stores seen",
                         cycle_count, store_count, exp_addr.size());
                error_count++;
                done = 1'b1;
            end
        end

        $display("Stores seen %0d of %0d, error count %0d",
                 store_count, exp_addr.size(), error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: rv_core_assert.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_core_assert (
    input logic             clk,
    input logic             arst_n,
    input logic [`XLEN-1:0] pc,
    input logic             fetch_stall,
    input logic             redirect,
    input logic             wr_en,
    input logic             rd_en,
    input logic [`XLEN-1:0] data_addr
);

    // One data access per cycle
    strobes_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(wr_en && rd_en))
        else $error("wr_en and rd_en are high in the same cycle");

    // Word accesses only
    data_addr_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        (wr_en || rd_en) |-> (data_addr[1:0] == 2'b00))
        else $error("data_addr %h is not word aligned", data_addr);

    // Back-pressure freezes fetch unless a branch or jump redirects it
    pc_holds_on_stall: assert property (@(posedge clk) disable iff (!arst_n)
        (fetch_stall && !redirect) |=> (pc == $past(pc)))
        else $error("pc moved while fetch_stall was high without a redirect");

    strobes_low_in_reset: assert property (@(posedge clk)
        !arst_n |-> (!wr_en && !rd_en))
        else $error("data strobe high during reset");

endmodule

bind rv_core rv_core_assert assert_inst0 (
    .clk(clk),
    .arst_n(arst_n),
    .pc(pc),
    .fetch_stall(fetch_stall),
    .redirect(redirect),
    .wr_en(wr_en),
    .rd_en(rd_en),
    .data_addr(data_addr)
);

// File: rv_core.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_core import rv_pkg::*; (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [`XLEN-1:0] instr,
    output logic [`XLEN-1:0] pc,
    input  logic             fetch_stall,
    output logic [`XLEN-1:0] data_addr,
    output logic [`XLEN-1:0] wr_data,
    output logic             wr_en,
    output logic             rd_en,
    input  logic [`XLEN-1:0] rd_data
);

    // Decode stage
    logic                  if_id_valid;
    logic [`XLEN-1:0]      if_id_pc;
    logic [`XLEN-1:0]      if_id_instr;
    logic [`REG_IDX_W-1:0] dec_rs1;
    logic [`REG_IDX_W-1:0] dec_rs2;
    logic [`REG_IDX_W-1:0] dec_rd;
    logic [`XLEN-1:0]      dec_imm;
    logic                  dec_rs1_used;
    logic                  dec_rs2_used;
    logic                  dec_rd_write;
    alu_op_e               dec_alu_op;
    logic                  dec_use_imm;
    logic                  dec_is_load;
    logic                  dec_is_store;
    logic                  dec_is_branch;
    logic                  dec_branch_ne;
    logic                  dec_is_jal;
    logic [`XLEN-1:0]      rf_rs1_value;
    logic [`XLEN-1:0]      rf_rs2_value;

    // Execute stage
    logic                  id_ex_valid;
    logic [`XLEN-1:0]      id_ex_pc;
    logic [`REG_IDX_W-1:0] id_ex_rs1;
    logic [`REG_IDX_W-1:0] id_ex_rs2;
    logic [`REG_IDX_W-1:0] id_ex_rd;
    logic [`XLEN-1:0]      id_ex_rs1_value;
    logic [`XLEN-1:0]      id_ex_rs2_value;
    logic [`XLEN-1:0]      id_ex_imm;
    alu_op_e               id_ex_alu_op;
    logic                  id_ex_use_imm;
    logic                  id_ex_rd_write;
    logic                  id_ex_is_load;
    logic                  id_ex_is_store;
    logic                  id_ex_is_branch;
    logic                  id_ex_branch_ne;
    logic                  id_ex_is_jal;
    logic [`XLEN-1:0]      ex_alu_result;
    logic [`XLEN-1:0]      ex_store_data;
    logic                  redirect;
    logic [`XLEN-1:0]      redirect_pc;
    fwd_sel_e              fwd_a;
    fwd_sel_e              fwd_b;
    logic                  load_use_stall;

    // Memory and writeback stages
    logic                  ex_mem_valid;
    logic [`REG_IDX_W-1:0] ex_mem_rd;
    logic                  ex_mem_rd_write;
    logic                  ex_mem_is_load;
    logic                  ex_mem_is_store;
    logic [`XLEN-1:0]      ex_mem_result;
    logic [`XLEN-1:0]      ex_mem_store_data;
    logic                  mem_wb_valid;
    logic [`REG_IDX_W-1:0] mem_wb_rd;
    logic                  mem_wb_rd_write;
    logic                  mem_wb_is_load;
    logic [`XLEN-1:0]      mem_wb_result;
    logic [`XLEN-1:0]      mem_wb_load_data;
    logic [`XLEN-1:0]      wb_value;
    logic                  wb_write;
    logic                  mem_write;

    logic                  front_hold;

    // Front end holds on either stall, a redirect overrides both
    assign front_hold = load_use_stall || fetch_stall;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `RESET_PC;
            if_id_valid <= 1'b0;
            if_id_instr <= `NOP_INSTR;
            id_ex_valid <= 1'b0;
            ex_mem_valid <= 1'b0;
            mem_wb_valid <= 1'b0;
        end else begin
            if (redirect) begin
                pc <= redirect_pc;
                if_id_valid <= 1'b0;
                if_id_instr <= `NOP_INSTR;
            end else if (!front_hold) begin
                pc <= pc + `XLEN'(4);
                if_id_valid <= 1'b1;
                if_id_instr <= instr;
            end
            id_ex_valid <= if_id_valid && !(redirect || front_hold);
            ex_mem_valid <= id_ex_valid;
            mem_wb_valid <= ex_mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!front_hold) begin
            if_id_pc <= pc;
        end
        id_ex_pc <= if_id_pc;
        id_ex_rs1 <= dec_rs1;
        id_ex_rs2 <= dec_rs2;
        id_ex_rd <= dec_rd;
        id_ex_rs1_value <= rf_rs1_value;
        id_ex_rs2_value <= rf_rs2_value;
        id_ex_imm <= dec_imm;
        id_ex_alu_op <= dec_alu_op;
        id_ex_use_imm <= dec_use_imm;
        id_ex_rd_write <= dec_rd_write;
        id_ex_is_load <= dec_is_load;
        id_ex_is_store <= dec_is_store;
        id_ex_is_branch <= dec_is_branch;
        id_ex_branch_ne <= dec_branch_ne;
        id_ex_is_jal <= dec_is_jal;
        ex_mem_rd <= id_ex_rd;
        ex_mem_rd_write <= id_ex_rd_write;
        ex_mem_is_load <= id_ex_is_load;
        ex_mem_is_store <= id_ex_is_store;
        ex_mem_result <= ex_alu_result;
        ex_mem_store_data <= ex_store_data;
        mem_wb_rd <= ex_mem_rd;
        mem_wb_rd_write <= ex_mem_rd_write;
        mem_wb_is_load <= ex_mem_is_load;
        mem_wb_result <= ex_mem_result;
        mem_wb_load_data <= rd_data;
    end

    rv_decoder dec_inst0 (
        .instr(if_id_instr),
        .rs1(dec_rs1),
        .rs2(dec_rs2),
        .rd(dec_rd),
        .imm(dec_imm),
        .rs1_used(dec_rs1_used),
        .rs2_used(dec_rs2_used),
        .rd_write(dec_rd_write),
        .alu_op(dec_alu_op),
        .use_imm(dec_use_imm),
        .is_load(dec_is_load),
        .is_store(dec_is_store),
        .is_branch(dec_is_branch),
        .branch_ne(dec_branch_ne),
        .is_jal(dec_is_jal)
    );

    rv_regfile rf_inst0 (
        .clk(clk),
        .arst_n(arst_n),
        .rs1(dec_rs1),
        .rs2(dec_rs2),
        .rs1_value(rf_rs1_value),
        .rs2_value(rf_rs2_value),
        .rd(mem_wb_rd),
        .rd_value(wb_value),
        .wr_en(wb_write)
    );

    rv_hazard_unit hazard_inst0 (
        .id_rs1(dec_rs1),
        .id_rs2(dec_rs2),
        .id_rs1_used(dec_rs1_used),
        .id_rs2_used(dec_rs2_used),
        .ex_rd(id_ex_rd),
        .ex_is_load(id_ex_valid && id_ex_is_load && id_ex_rd_write),
        .ex_rs1(id_ex_rs1),
        .ex_rs2(id_ex_rs2),
        .mem_rd(ex_mem_rd),
        .mem_rd_write(mem_write),
        .wb_rd(mem_wb_rd),
        .wb_rd_write(wb_write),
        .load_use_stall(load_use_stall),
        .fwd_a(fwd_a),
        .fwd_b(fwd_b)
    );

    rv_execute ex_inst0 (
        .pc(id_ex_pc),
        .rs1_value(id_ex_rs1_value),
        .rs2_value(id_ex_rs2_value),
        .imm(id_ex_imm),
        .alu_op(id_ex_alu_op),
        .use_imm(id_ex_use_imm),
        .is_branch(id_ex_valid && id_ex_is_branch),
        .branch_ne(id_ex_branch_ne),
        .is_jal(id_ex_valid && id_ex_is_jal),
        .fwd_a(fwd_a),
        .fwd_b(fwd_b),
        .mem_result(ex_mem_result),
        .wb_value(wb_value),
        .alu_result(ex_alu_result),
        .store_data(ex_store_data),
        .redirect(redirect),
        .redirect_pc(redirect_pc)
    );

    // Memory stage drives the data port
    assign data_addr = ex_mem_result;
    assign wr_data   = ex_mem_store_data;
    assign wr_en     = ex_mem_valid && ex_mem_is_store;
    assign rd_en     = ex_mem_valid && ex_mem_is_load;
    assign mem_write = ex_mem_valid && ex_mem_rd_write;

    // Writeback
    assign wb_value = mem_wb_is_load ? mem_wb_load_data : mem_wb_result;
    assign wb_write = mem_wb_valid && mem_wb_rd_write;

endmodule

// File: rv_execute.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_execute import rv_pkg::*; (
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] rs1_value,
    input  logic [`XLEN-1:0] rs2_value,
    input  logic [`XLEN-1:0] imm,
    input  alu_op_e          alu_op,
    input  logic             use_imm,
    input  logic             is_branch,
    input  logic             branch_ne,
    input  logic             is_jal,
    input  fwd_sel_e         fwd_a,
    input  fwd_sel_e         fwd_b,
    input  logic [`XLEN-1:0] mem_result,
    input  logic [`XLEN-1:0] wb_value,
    output logic [`XLEN-1:0] alu_result,
    output logic [`XLEN-1:0] store_data,
    output logic             redirect,
    output logic [`XLEN-1:0] redirect_pc
);

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b_reg;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_out;
    logic             operands_equal;
    logic             branch_taken;

    function automatic logic [`XLEN-1:0] forward(input fwd_sel_e sel,
                                                 input logic [`XLEN-1:0] reg_value);
        case (sel)
            FWD_MEM: return mem_result;
            FWD_WB:  return wb_value;
            default: return reg_value;
        endcase
    endfunction

    always_comb begin
        op_a = forward(fwd_a, rs1_value);
        op_b_reg = forward(fwd_b, rs2_value);
        op_b = use_imm ? imm : op_b_reg;
        case (alu_op)
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_OR:     alu_out = op_a | op_b;
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SLT:    alu_out = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = op_a + op_b;
        endcase
    end

    // JAL writes the link address, loads and stores use the sum as address
    assign alu_result = is_jal ? (pc + `XLEN'(4)) : alu_out;
    assign store_data = op_b_reg;

    // Branches compare the register operands, never the immediate
    assign operands_equal = (op_a == op_b_reg);
    assign branch_taken   = is_branch && (branch_ne ? !operands_equal : operands_equal);
    assign redirect       = branch_taken || is_jal;
    assign redirect_pc    = pc + imm;

endmodule

// File: rv_hazard_unit.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_hazard_unit import rv_pkg::*; (
    input  logic [`REG_IDX_W-1:0] id_rs1,
    input  logic [`REG_IDX_W-1:0] id_rs2,
    input  logic                  id_rs1_used,
    input  logic                  id_rs2_used,
    input  logic [`REG_IDX_W-1:0] ex_rd,
    input  logic                  ex_is_load,
    input  logic [`REG_IDX_W-1:0] ex_rs1,
    input  logic [`REG_IDX_W-1:0] ex_rs2,
    input  logic [`REG_IDX_W-1:0] mem_rd,
    input  logic                  mem_rd_write,
    input  logic [`REG_IDX_W-1:0] wb_rd,
    input  logic                  wb_rd_write,
    output logic                  load_use_stall,
    output fwd_sel_e              fwd_a,
    output fwd_sel_e              fwd_b
);

    // Youngest producer wins, so memory is checked before writeback
    function automatic fwd_sel_e pick_source(input logic [`REG_IDX_W-1:0] src);
        if (mem_rd_write && (mem_rd == src)) begin
            return FWD_MEM;
        end
        if (wb_rd_write && (wb_rd == src)) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    // ex_is_load only comes in for loads that write a register
    assign load_use_stall = ex_is_load &&
                            ((id_rs1_used && (id_rs1 == ex_rd)) ||
                             (id_rs2_used && (id_rs2 == ex_rd)));

    always_comb begin
        fwd_a = pick_source(ex_rs1);
        fwd_b = pick_source(ex_rs2);
    end

endmodule

// File: rv_regfile.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_regfile (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [`REG_IDX_W-1:0] rs1,
    input  logic [`REG_IDX_W-1:0] rs2,
    output logic [`XLEN-1:0]      rs1_value,
    output logic [`XLEN-1:0]      rs2_value,
    input  logic [`REG_IDX_W-1:0] rd,
    input  logic [`XLEN-1:0]      rd_value,
    input  logic                  wr_en
);

    // Storage for x1 to x31 only
    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[rd] <= rd_value;
        end
    end

    // Same-cycle write is visible to decode
    always_comb begin
        if (rs1 == '0) begin
            rs1_value = '0;
        end else if (wr_en && (rd == rs1)) begin
            rs1_value = rd_value;
        end else begin
            rs1_value = regs[rs1];
        end
        if (rs2 == '0) begin
            rs2_value = '0;
        end else if (wr_en && (rd == rs2)) begin
            rs2_value = rd_value;
        end else begin
            rs2_value = regs[rs2];
        end
    end

endmodule

// File: rv_decoder.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_decoder import rv_pkg::*; (
    input  logic [`XLEN-1:0]      instr,
    output logic [`REG_IDX_W-1:0] rs1,
    output logic [`REG_IDX_W-1:0] rs2,
    output logic [`REG_IDX_W-1:0] rd,
    output logic [`XLEN-1:0]      imm,
    output logic                  rs1_used,
    output logic                  rs2_used,
    output logic                  rd_write,
    output alu_op_e               alu_op,
    output logic                  use_imm,
    output logic                  is_load,
    output logic                  is_store,
    output logic                  is_branch,
    output logic                  branch_ne,
    output logic                  is_jal
);

    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;
    logic             legal;
    logic             write_rd;

    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        legal = 1'b1;
        write_rd = 1'b0;
        rs1_used = 1'b0;
        rs2_used = 1'b0;
        alu_op = ALU_ADD;
        use_imm = 1'b0;
        imm = imm_i;
        is_load = 1'b0;
        is_store = 1'b0;
        is_branch = 1'b0;
        branch_ne = 1'b0;
        is_jal = 1'b0;
        case (opcode_e'(instr[6:0]))
            OP: begin
                case ({funct7, funct3})
                    {7'h00, 3'b000}: alu_op = ALU_ADD;
                    {7'h20, 3'b000}: alu_op = ALU_SUB;
                    {7'h00, 3'b111}: alu_op = ALU_AND;
                    {7'h00, 3'b110}: alu_op = ALU_OR;
                    {7'h00, 3'b100}: alu_op = ALU_XOR;
                    {7'h00, 3'b010}: alu_op = ALU_SLT;
                    default: legal = 1'b0;
                endcase
                rs1_used = legal;
                rs2_used = legal;
                write_rd = legal;
            end
            OP_IMM: begin
                case (funct3)
                    3'b000: alu_op = ALU_ADD;
                    3'b111: alu_op = ALU_AND;
                    3'b110: alu_op = ALU_OR;
                    3'b100: alu_op = ALU_XOR;
                    3'b010: alu_op = ALU_SLT;
                    default: legal = 1'b0;
                endcase
                use_imm = 1'b1;
                rs1_used = legal;
                write_rd = legal;
            end
            LOAD: begin
                // Word loads only
                legal = (funct3 == 3'b010);
                use_imm = 1'b1;
                rs1_used = legal;
                write_rd = legal;
                is_load = legal;
            end
            STORE: begin
                legal = (funct3 == 3'b010);
                use_imm = 1'b1;
                imm = imm_s;
                rs1_used = legal;
                rs2_used = legal;
                is_store = legal;
            end
            BRANCH: begin
                // BEQ and BNE differ in funct3 bit 0
                legal = (funct3[2:1] == 2'b00);
                imm = imm_b;
                rs1_used = legal;
                rs2_used = legal;
                is_branch = legal;
                branch_ne = funct3[0];
            end
            JAL: begin
                imm = imm_j;
                write_rd = 1'b1;
                is_jal = 1'b1;
            end
            LUI: begin
                alu_op = ALU_PASS_B;
                use_imm = 1'b1;
                imm = imm_u;
                write_rd = 1'b1;
            end
            default: legal = 1'b0;
        endcase
    end

    // Writes to x0 are dropped here
    assign rd_write = write_rd && (rd != '0);

endmodule

// File: rv_pkg.sv
package rv_pkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SLT    = 3'd5,
        // LUI passes the U immediate through
        ALU_PASS_B = 3'd6
    } alu_op_e;

    // Operand source for execute
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_MEM  = 2'd1,
        FWD_WB   = 2'd2
    } fwd_sel_e;

endpackage

// File: rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Data and address width, one word
`define XLEN 32

// Architectural registers, x0 included
`define REG_COUNT 32
`define REG_IDX_W $clog2(`REG_COUNT)

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// ADDI x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`endif
